// ==== icache_bypass.f ====
hw/icache_cfg_pkg.sv
hw/icache_bus_pkg.sv
hw/bypass_port_fsm.sv
hw/bypass_order_fifo.sv
hw/bypass_fetch.sv
hw/wb_line_refill.sv
hw/icache_bypass_top.sv
verif/icache_bypass_properties.sv
verif/icache_bypass_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache bypass path

VERILATOR ?= verilator
TOP       ?= icache_bypass_tb
FILELIST  ?= icache_bypass.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it reports a pass"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/icache_bypass_tb.sv ====
// Instruction cache bypass testbench
// Drives both fetch ports against a Wishbone memory model with random wait
// states and checks every fetch response against a reference model
`timescale 1ns/1ps

module icache_bypass_tb;

    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES = 16;
    localparam int RNG_SEED = 23758;
    localparam int STREAM_LEN = 80;
    localparam int MAX_FETCHES = 200;
    localparam int CYCLES_PER_FETCH = 40;
    localparam int TIMEOUT_CYCLES = MAX_FETCHES * CYCLES_PER_FETCH;
    localparam fill_word_t MEM_PATTERN = 32'hC0DE_F00D;
    localparam logic [7:0] ERR_REGION = 8'hEE;

    logic clk = 1'b0;
    logic arst_n;
    port_mask_t inst_valid;
    addr_t [NR_FETCH_PORTS-1:0] inst_addr;
    port_mask_t inst_ready;
    fetch_rsp_t [NR_FETCH_PORTS-1:0] inst_rsp;
    wb_m2s_t wb_m2s;
    wb_s2m_t wb_s2m = '0;

    int check_cnt = 0;
    int error_cnt = 0;
    int fetch_issued = 0;
    int fetch_done = 0;
    int refill_cnt = 0;
    int cycle_cnt = 0;
    int wait_cnt = -1;
    int beat_cnt = 0;
    logic in_burst = 1'b0;
    addr_t burst_base = '0;

    icache_bypass_top dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .inst_valid_i (inst_valid),
        .inst_addr_i  (inst_addr),
        .inst_ready_o (inst_ready),
        .inst_rsp_o   (inst_rsp),
        .wb_o         (wb_m2s),
        .wb_i         (wb_s2m)
    );

    always #(HALF_PERIOD_NS) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Memory word at byte address A reads as A XOR the pattern
    function automatic fetch_rsp_t expected_fetch(input addr_t addr);
        fetch_rsp_t rsp;
        addr_t word_addr;
        word_addr = {addr[FETCH_AW-1:FETCH_ALIGN], FETCH_ALIGN'(0)};
        rsp.data = word_addr ^ MEM_PATTERN;
        rsp.err = (addr[FETCH_AW-1:FETCH_AW-8] == ERR_REGION);
        return rsp;
    endfunction

    // Line base of a port that still holds its request, preferring the line
    // that the new burst opened when several ports are waiting
    function automatic addr_t requested_line(input addr_t adr);
        addr_t line;
        addr_t base;
        base = '1;
        for (int p = 0; p < NR_FETCH_PORTS; p++) begin
            line = {inst_addr[p][FETCH_AW-1:LINE_ALIGN], LINE_ALIGN'(0)};
            if (inst_valid[p] && (base == '1 || line == adr)) begin
                base = line;
            end
        end
        return base;
    endfunction

    // About one fetch in sixteen lands in the error region
    function automatic addr_t random_addr();
        addr_t a;
        a = $urandom();
        a[FETCH_ALIGN-1:0] = '0;
        if ($urandom_range(15, 0) == 0) begin
            a[FETCH_AW-1:FETCH_AW-8] = ERR_REGION;
        end else if (a[FETCH_AW-1:FETCH_AW-8] == ERR_REGION) begin
            a[FETCH_AW-1:FETCH_AW-8] = 8'h00;
        end
        return a;
    endfunction

    task automatic run_fetch(input int p, input addr_t a);
        @(posedge clk);
        inst_valid[p] <= 1'b1;
        inst_addr[p] <= a;
        fetch_issued++;
        do begin
            @(posedge clk);
        end while (!inst_ready[p]);
        // Drop valid in the ready cycle so the port returns to idle
        inst_valid[p] <= 1'b0;
    endtask

    task automatic run_stream(input int p, input int count);
        repeat (count) begin
            repeat ($urandom_range(2, 0)) @(posedge clk);
            run_fetch(p, random_addr());
        end
    endtask

    // Wishbone slave with 0 to 3 wait cycles per beat, also tracks each burst
    always @(posedge clk) begin
        if (!wb_m2s.cyc && in_burst) begin
            check_value("wb beat count", 64'(beat_cnt), 64'(BEATS_PER_LINE));
            in_burst = 1'b0;
            refill_cnt++;
        end
        if (wb_s2m.ack || wb_s2m.err) begin
            wb_s2m.ack <= 1'b0;
            wb_s2m.err <= 1'b0;
        end else if (wb_m2s.cyc && wb_m2s.stb) begin
            if (!in_burst) begin
                in_burst = 1'b1;
                beat_cnt = 0;
                burst_base = requested_line(wb_m2s.adr);
                check_value("wb_o.adr", 64'(wb_m2s.adr), 64'(burst_base));
            end
            if (wait_cnt < 0) begin
                wait_cnt = $urandom_range(3, 0);
            end
            if (wait_cnt == 0) begin
                check_value("wb_o.adr", 64'(wb_m2s.adr),
                            64'(burst_base + addr_t'(beat_cnt * (FILL_DW / 8))));
                check_value("wb_o.sel", 64'(wb_m2s.sel), 64'(4'hF));
                beat_cnt++;
                wait_cnt = -1;
                wb_s2m.ack <= (wb_m2s.adr[FETCH_AW-1:FETCH_AW-8] != ERR_REGION);
                wb_s2m.err <= (wb_m2s.adr[FETCH_AW-1:FETCH_AW-8] == ERR_REGION);
                wb_s2m.dat <= wb_m2s.adr ^ MEM_PATTERN;
            end else begin
                wait_cnt--;
            end
        end
    end

    // Each ready pulse is checked against the address still held on its port
    always @(posedge clk) begin
        for (int p = 0; p < NR_FETCH_PORTS; p++) begin
            if (inst_ready[p]) begin
                check_value($sformatf("inst_rsp_o[%0d]", p), 64'(inst_rsp[p]),
                            64'(expected_fetch(inst_addr[p])));
                fetch_done++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, only %0d of %0d fetches completed",
                     cycle_cnt, fetch_done, fetch_issued);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        addr_t a0;
        addr_t a1;
        addr_t line_base;
        void'($urandom(RNG_SEED));
        arst_n = 1'b0;
        inst_valid = '0;
        inst_addr = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // Nothing moves before the first request
        repeat (8) begin
            @(posedge clk);
            check_value("inst_ready_o", 64'(inst_ready), 64'(0));
            check_value("wb_o.cyc", 64'(wb_m2s.cyc), 64'(0));
            check_value("wb_o.stb", 64'(wb_m2s.stb), 64'(0));
        end

        line_base = random_addr();
        line_base[LINE_ALIGN-1:0] = '0;
        for (int w = 0; w < BEATS_PER_LINE; w++) begin
            run_fetch(0, line_base + addr_t'(w * (FETCH_DW / 8)));
        end

        // Concurrent fetches to different lines on both ports
        repeat (8) begin
            a0 = random_addr();
            a1 = random_addr();
            while (a1[FETCH_AW-1:LINE_ALIGN] == a0[FETCH_AW-1:LINE_ALIGN]) begin
                a1 = random_addr();
            end
            fork
                run_fetch(0, a0);
                run_fetch(1, a1);
            join
        end

        run_fetch(0, 32'hEE00_0124);
        check_value("inst_rsp_o[0].err", 64'(inst_rsp[0].err), 64'(1));
        run_fetch(0, 32'h0000_0124);
        check_value("inst_rsp_o[0].err", 64'(inst_rsp[0].err), 64'(0));

        fork
            run_stream(0, STREAM_LEN);
            run_stream(1, STREAM_LEN);
        join

        repeat (4) @(posedge clk);
        check_value("completed fetches", 64'(fetch_done), 64'(fetch_issued));
        $display("Summary: %0d checks, %0d errors, %0d fetches, %0d refills",
                 check_cnt, error_cnt, fetch_done, refill_cnt);
        if (error_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/icache_bypass_properties.sv ====
// Instruction cache bypass protocol properties
// Concurrent checks on the Wishbone refill port and the fetch ready pulses
`timescale 1ns/1ps

module icache_bypass_properties (
    input logic                       clk_i,
    input logic                       arst_n_i,
    input icache_bus_pkg::wb_m2s_t    wb_o,
    input icache_bus_pkg::wb_s2m_t    wb_i,
    input icache_cfg_pkg::port_mask_t inst_ready_o
);

    stb_within_cyc: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        wb_o.stb |-> wb_o.cyc
    ) else $error("Wishbone stb is high without cyc");

    // A classic cycle holds its address until the slave answers
    stb_held_until_answer: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (wb_o.stb && !wb_i.ack && !wb_i.err) |=> (wb_o.stb && $stable(wb_o.adr))
    ) else $error("Wishbone adr or stb changed before ack or err");

    ready_is_pulse: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (inst_ready_o & $past(inst_ready_o)) == '0
    ) else $error("inst_ready_o stayed high for two cycles");

endmodule

bind icache_bypass_top icache_bypass_properties u_properties (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .wb_o         (wb_o),
    .wb_i         (wb_i),
    .inst_ready_o (inst_ready_o)
);

// ==== hw/icache_bypass_top.sv ====
// Instruction cache bypass path
// Connects the fetch ports through the bypass arbitration to the Wishbone
// line refill master
`timescale 1ns/1ps

module icache_bypass_top (
    input  logic                                                     clk_i,
    input  logic                                                     arst_n_i,
    input  icache_cfg_pkg::port_mask_t                               inst_valid_i,
    input  icache_cfg_pkg::addr_t [icache_cfg_pkg::NR_FETCH_PORTS-1:0] inst_addr_i,
    output icache_cfg_pkg::port_mask_t                               inst_ready_o,
    output icache_bus_pkg::fetch_rsp_t [icache_cfg_pkg::NR_FETCH_PORTS-1:0] inst_rsp_o,
    output icache_bus_pkg::wb_m2s_t                                  wb_o,
    input  icache_bus_pkg::wb_s2m_t                                  wb_i
);

    import icache_bus_pkg::*;

    refill_req_t refill_req;
    refill_rsp_t refill_rsp;
    logic refill_req_valid, refill_req_ready;
    logic refill_rsp_valid, refill_rsp_ready;

    bypass_fetch u_bypass_fetch (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_addr_i  (inst_addr_i),
        .inst_ready_o (inst_ready_o),
        .inst_rsp_o   (inst_rsp_o),
        .req_o        (refill_req),
        .req_valid_o  (refill_req_valid),
        .req_ready_i  (refill_req_ready),
        .rsp_i        (refill_rsp),
        .rsp_valid_i  (refill_rsp_valid),
        .rsp_ready_o  (refill_rsp_ready)
    );

    wb_line_refill u_wb_line_refill (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (refill_req),
        .req_valid_i (refill_req_valid),
        .req_ready_o (refill_req_ready),
        .rsp_o       (refill_rsp),
        .rsp_valid_o (refill_rsp_valid),
        .rsp_ready_i (refill_rsp_ready),
        .wb_o        (wb_o),
        .wb_i        (wb_i)
    );

endmodule

// ==== hw/wb_line_refill.sv ====
// Wishbone line refill master
// Reads one cache line as consecutive classic Wishbone beats, assembles the
// beats into a line and hands it back with a sticky error flag
`timescale 1ns/1ps

module wb_line_refill (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  icache_bus_pkg::refill_req_t req_i,
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    output icache_bus_pkg::refill_rsp_t rsp_o,
    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,
    output icache_bus_pkg::wb_m2s_t     wb_o,
    input  icache_bus_pkg::wb_s2m_t     wb_i
);

    import icache_cfg_pkg::*;

    typedef enum logic [1:0] {
        Idle, Burst, Respond
    } state_e;

    state_e state_q;
    beat_idx_t beat_q;
    addr_t base_q;
    logic err_q;
    fill_word_t [BEATS_PER_LINE-1:0] line_q;
    logic beat_done;

    assign req_ready_o = (state_q == Idle);
    assign rsp_valid_o = (state_q == Respond);
    assign beat_done = (state_q == Burst) && (wb_i.ack || wb_i.err);

    assign wb_o.cyc = (state_q == Burst);
    assign wb_o.stb = (state_q == Burst);
    assign wb_o.adr = base_q + (addr_t'(beat_q) << $clog2(FILL_DW / 8));
    assign wb_o.sel = '1;

    // Beat 0 lands in the lowest bits of the line
    assign rsp_o.data = line_q;
    assign rsp_o.err = err_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= Idle;
            beat_q <= '0;
            err_q <= 1'b0;
        end else begin
            case (state_q)
                Idle: begin
                    if (req_valid_i) begin
                        beat_q <= '0;
                        err_q <= 1'b0;
                        state_q <= Burst;
                    end
                end
                Burst: begin
                    if (beat_done) begin
                        err_q <= err_q | wb_i.err;
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == beat_idx_t'(BEATS_PER_LINE - 1)) begin
                            state_q <= Respond;
                        end
                    end
                end
                Respond: begin
                    if (rsp_ready_i) begin
                        state_q <= Idle;
                    end
                end
                default: state_q <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            base_q <= req_i.addr;
        end
        if (beat_done) begin
            line_q[beat_q] <= wb_i.dat;
        end
    end

endmodule

// ==== hw/bypass_fetch.sv ====
// Bypass fetch arbitration
// Round-robin arbitration of the per-port FSMs onto one refill request
// channel, with responses steered back through the order FIFO
`timescale 1ns/1ps

module bypass_fetch #(
    parameter int NR_PORTS = icache_cfg_pkg::NR_FETCH_PORTS
) (
    input  logic                                       clk_i,
    input  logic                                       arst_n_i,
    input  icache_cfg_pkg::port_mask_t                 inst_valid_i,
    input  icache_cfg_pkg::addr_t [NR_PORTS-1:0]       inst_addr_i,
    output icache_cfg_pkg::port_mask_t                 inst_ready_o,
    output icache_bus_pkg::fetch_rsp_t [NR_PORTS-1:0]  inst_rsp_o,
    output icache_bus_pkg::refill_req_t                req_o,
    output logic                                       req_valid_o,
    input  logic                                       req_ready_i,
    input  icache_bus_pkg::refill_rsp_t                rsp_i,
    input  logic                                       rsp_valid_i,
    output logic                                       rsp_ready_o
);

    import icache_cfg_pkg::*;

    localparam int IDX_W = (NR_PORTS > 1) ? $clog2(NR_PORTS) : 1;

    port_mask_t grant_req, grant_oh, port_rsp_valid, fifo_head;
    logic [IDX_W-1:0] rr_ptr_q, grant_idx;
    logic fifo_full, fifo_empty, accept;

    // Search starts at the port after the last winner
    always_comb begin
        int idx;
        logic found;
        grant_oh = '0;
        grant_idx = '0;
        found = 1'b0;
        for (int k = 0; k < NR_PORTS; k++) begin
            idx = (int'(rr_ptr_q) + k) % NR_PORTS;
            if (!found && grant_req[idx]) begin
                grant_oh[idx] = 1'b1;
                grant_idx = IDX_W'(idx);
                found = 1'b1;
            end
        end
    end

    assign req_valid_o = |grant_req;
    assign req_o.addr = {inst_addr_i[grant_idx][FETCH_AW-1:LINE_ALIGN], LINE_ALIGN'(0)};
    assign accept = req_valid_o && req_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr_q <= '0;
        end else if (accept) begin
            rr_ptr_q <= (grant_idx == IDX_W'(NR_PORTS - 1)) ? '0 : grant_idx + 1'b1;
        end
    end

    bypass_order_fifo #(
        .DEPTH (ORDER_FIFO_DEPTH)
    ) u_order_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .push_i   (accept),
        .mask_i   (grant_oh),
        .pop_i    (rsp_valid_i && rsp_ready_o),
        .full_o   (fifo_full),
        .head_o   (fifo_head),
        .empty_o  (fifo_empty)
    );

    // The head port is always waiting, so a queued refill is all that is needed
    assign rsp_ready_o = !fifo_empty;
    assign port_rsp_valid = fifo_head & {NR_PORTS{rsp_valid_i && !fifo_empty}};

    for (genvar p = 0; p < NR_PORTS; p++) begin : gen_port
        bypass_port_fsm u_port (
            .clk_i       (clk_i),
            .arst_n_i    (arst_n_i),
            .valid_i     (inst_valid_i[p]),
            .addr_i      (inst_addr_i[p]),
            .grant_req_o (grant_req[p]),
            .granted_i   (grant_oh[p] && req_ready_i),
            .fifo_full_i (fifo_full),
            .rsp_valid_i (port_rsp_valid[p]),
            .line_i      (rsp_i),
            .ready_o     (inst_ready_o[p]),
            .rsp_o       (inst_rsp_o[p])
        );
    end

endmodule

// ==== hw/bypass_order_fifo.sv ====
// Refill order FIFO
// Holds the one-hot mask of each granted port so that refill responses,
// which return in request order, find their way back to the right port
`timescale 1ns/1ps

module bypass_order_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       push_i,
    input  icache_cfg_pkg::port_mask_t mask_i,
    input  logic                       pop_i,
    output logic                       full_o,
    output icache_cfg_pkg::port_mask_t head_o,
    output logic                       empty_o
);

    import icache_cfg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    port_mask_t mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic do_push, do_pop;

    assign full_o = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o = mem_q[rd_ptr_q];

    assign do_push = push_i && !full_o;
    assign do_pop = pop_i && !empty_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the fill level unchanged
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= mask_i;
        end
    end

endmodule

// ==== hw/bypass_port_fsm.sv ====
// Bypass fetch port FSM
// Takes one fetch request, asks the arbiter for a refill grant, picks the
// requested word out of the returned line and presents it for one cycle
`timescale 1ns/1ps

module bypass_port_fsm (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        valid_i,
    input  icache_cfg_pkg::addr_t       addr_i,
    output logic                        grant_req_o,
    input  logic                        granted_i,
    input  logic                        fifo_full_i,
    input  logic                        rsp_valid_i,
    input  icache_bus_pkg::refill_rsp_t line_i,
    output logic                        ready_o,
    output icache_bus_pkg::fetch_rsp_t  rsp_o
);

    import icache_cfg_pkg::*;

    typedef enum logic [1:0] {
        Idle, RequestData, WaitResponse, PresentResponse
    } state_e;

    state_e state_q, state_d;
    logic   capture;
    logic [LINE_ALIGN-FETCH_ALIGN-1:0] word_sel;
    fetch_word_t word;

    // Word offset within the line comes straight from the held address
    assign word_sel = addr_i[LINE_ALIGN-1:FETCH_ALIGN];
    assign word = line_i.data[word_sel*FETCH_DW +: FETCH_DW];

    always_comb begin
        state_d = state_q;
        grant_req_o = 1'b0;
        capture = 1'b0;
        ready_o = 1'b0;
        case (state_q)
            Idle: begin
                if (valid_i) begin
                    state_d = RequestData;
                end
            end
            RequestData: begin
                // Only compete for the bus while the response can still be tracked
                grant_req_o = !fifo_full_i;
                if (granted_i) begin
                    state_d = WaitResponse;
                end
            end
            WaitResponse: begin
                if (rsp_valid_i) begin
                    capture = 1'b1;
                    state_d = PresentResponse;
                end
            end
            PresentResponse: begin
                ready_o = 1'b1;
                state_d = Idle;
            end
            default: state_d = Idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= Idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            rsp_o.data <= word;
            rsp_o.err <= line_i.err;
        end
    end

endmodule

// ==== hw/icache_bus_pkg.sv ====
// Instruction cache bus bundles
// Payloads of the fetch response, the refill request and response, and the
// two directions of the read-only Wishbone classic refill port
package icache_bus_pkg;

    import icache_cfg_pkg::*;

    typedef struct packed {
        fetch_word_t data;
        logic        err;
    } fetch_rsp_t;

    // Address is always aligned to a line boundary
    typedef struct packed {
        addr_t addr;
    } refill_req_t;

    typedef struct packed {
        line_t data;
        logic  err;
    } refill_rsp_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        addr_t                  adr;
        logic [FILL_DW/8-1:0]   sel;
    } wb_m2s_t;

    typedef struct packed {
        logic       ack;
        logic       err;
        fill_word_t dat;
    } wb_s2m_t;

endpackage

// ==== hw/icache_cfg_pkg.sv ====
// Instruction cache configuration
// Geometry constants of the bypass fetch path and the vector types whose
// widths carry a meaning across the design
package icache_cfg_pkg;

    // Fetch side and refill bus widths
    localparam int FETCH_AW = 32;
    localparam int FETCH_DW = 32;
    localparam int FILL_DW = 32;
    localparam int LINE_WIDTH = 128;
    localparam int NR_FETCH_PORTS = 2;

    // Byte offsets inside a line and inside a fetch word
    localparam int LINE_ALIGN = $clog2(LINE_WIDTH / 8);
    localparam int FETCH_ALIGN = $clog2(FETCH_DW / 8);
    localparam int BEATS_PER_LINE = LINE_WIDTH / FILL_DW;

    // Outstanding refills that the order FIFO can track
    localparam int ORDER_FIFO_DEPTH = 4;

    typedef logic [FETCH_AW-1:0] addr_t;
    typedef logic [FETCH_DW-1:0] fetch_word_t;
    typedef logic [FILL_DW-1:0] fill_word_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [NR_FETCH_PORTS-1:0] port_mask_t;
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

endpackage
